// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := nts_engine_tb
FILELIST  := files.f

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SIM_LOG   := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) +verilator+error+limit+1000 2>&1 | tee $(SIM_LOG)
	grep -q "^TB PASSED$$" $(SIM_LOG)

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)

// ==== files.f ====
src/nts_api_pkg.sv
src/nts_txbuf_pkg.sv
src/nts_api_decode.sv
src/nts_stat_counter.sv
src/nts_debug_regs.sv
src/nts_tx_write_mux.sv
src/nts_engine.sv
tests/nts_clk_gen.sv
tests/nts_engine_chk.sv
tests/nts_engine_tb.sv

// ==== src/nts_api_decode.sv ====
// Read data is combinational and valid in the cycle of the request; unknown blocks read zero
`default_nettype none
`timescale 1ns/1ps

module nts_api_decode
  import nts_api_pkg::*;
(
  input  api_req_t              i_api,
  output api_bus_t              o_bus,
  output logic                  o_cs_debug,
  input  logic [API_DATA_W-1:0] i_debug_rdata,
  output logic [API_DATA_W-1:0] o_api_read_data
);

  logic [API_BLK_W-1:0]  blk_sel;
  logic [API_REG_W-1:0]  reg_addr;
  logic                  rd_cycle;
  logic [API_DATA_W-1:0] engine_rdata;

  assign blk_sel  = i_api.address[API_ADDR_W-1:API_REG_W];
  assign reg_addr = i_api.address[API_REG_W-1:0];
  assign rd_cycle = i_api.cs && !i_api.we;

  // Shared bus towards the blocks
  assign o_bus.we         = i_api.we;
  assign o_bus.address    = reg_addr;
  assign o_bus.write_data = i_api.write_data;
  assign o_cs_debug       = i_api.cs && (blk_sel == BLK_DEBUG);

  // --------------------------------------------------------------------------
  // Engine identity table
  // --------------------------------------------------------------------------
  always_comb
  begin
    case (reg_addr)
      REG_NAME0:   engine_rdata = CORE_NAME0;
      REG_NAME1:   engine_rdata = CORE_NAME1;
      REG_VERSION: engine_rdata = CORE_VERSION;
      REG_CTRL:    engine_rdata = CTRL_VALUE;
      default:     engine_rdata = '0; // Unmapped
    endcase
  end

  // Read data merge, zero on writes and idle cycles
  always_comb
  begin
    o_api_read_data = '0;
    if (rd_cycle)
    begin
      case (blk_sel)
        BLK_ENGINE: o_api_read_data = engine_rdata;
        BLK_DEBUG:  o_api_read_data = i_debug_rdata;
        default:    o_api_read_data = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/nts_api_pkg.sv ====
// API map assumes one 32-bit read port with no wait states; writes are ignored by every block
`default_nettype none

package nts_api_pkg;

  // --------------------------------------------------------------------------
  // API widths and block selects
  // --------------------------------------------------------------------------
  localparam int API_ADDR_W = 12;
  localparam int API_DATA_W = 32;
  localparam int API_REG_W  = 8;
  localparam int API_BLK_W  = API_ADDR_W - API_REG_W; // Select from address bits 11..8

  localparam logic [API_BLK_W-1:0] BLK_ENGINE = 4'd0;
  localparam logic [API_BLK_W-1:0] BLK_DEBUG  = 4'd1;

  // Engine identity block
  localparam logic [API_REG_W-1:0]  REG_NAME0    = 8'h00;
  localparam logic [API_REG_W-1:0]  REG_NAME1    = 8'h01;
  localparam logic [API_REG_W-1:0]  REG_VERSION  = 8'h02;
  localparam logic [API_REG_W-1:0]  REG_CTRL     = 8'h08;
  localparam logic [API_DATA_W-1:0] CORE_NAME0   = 32'h4e54_535f; // "NTS_"
  localparam logic [API_DATA_W-1:0] CORE_NAME1   = 32'h454e_474e; // "ENGN"
  localparam logic [API_DATA_W-1:0] CORE_VERSION = 32'h302e_3031; // "0.01"
  localparam logic [API_DATA_W-1:0] CTRL_VALUE   = 32'h0000_0001;

  // --------------------------------------------------------------------------
  // Debug statistics block
  // --------------------------------------------------------------------------
  localparam logic [API_REG_W-1:0] DBG_PROCESSED  = 8'h00; // Upper half, snapshot at +1
  localparam logic [API_REG_W-1:0] DBG_BAD_COOKIE = 8'h02;
  localparam logic [API_REG_W-1:0] DBG_BAD_AUTH   = 8'h04;
  localparam logic [API_REG_W-1:0] DBG_BAD_KEYID  = 8'h06;
  localparam logic [API_REG_W-1:0] DBG_NAME       = 8'h08;
  localparam logic [API_REG_W-1:0] DBG_SYSTICK    = 8'h09;
  localparam logic [API_REG_W-1:0] DBG_ERR_CRYPTO = 8'h20;
  localparam logic [API_REG_W-1:0] DBG_ERR_TXBUF  = 8'h22;

  localparam logic [API_DATA_W-1:0] DEBUG_NAME    = 32'h4442_5547; // "DBUG"
  localparam logic [API_DATA_W-1:0] SYSTICK_RESET = 32'h0000_0001;

  // Counter offsets, same order as stat_events_t
  localparam int STAT_N = 6;
  localparam logic [API_REG_W-1:0] DBG_CNT_OFS [STAT_N] = '{
    DBG_PROCESSED, DBG_BAD_COOKIE, DBG_BAD_AUTH,
    DBG_BAD_KEYID, DBG_ERR_CRYPTO, DBG_ERR_TXBUF
  };

  typedef struct packed {
    logic                  cs;
    logic                  we;
    logic [API_ADDR_W-1:0] address;
    logic [API_DATA_W-1:0] write_data;
  } api_req_t;

  typedef struct packed {
    logic                  we;
    logic [API_REG_W-1:0]  address;
    logic [API_DATA_W-1:0] write_data;
  } api_bus_t;

  // One-cycle event pulses
  typedef struct packed {
    logic processed;
    logic bad_cookie;
    logic bad_auth;
    logic bad_keyid;
    logic err_crypto;
    logic err_txbuf;
  } stat_events_t;

endpackage

`default_nettype wire

// ==== src/nts_debug_regs.sv ====
// Reading a counter's upper half takes the snapshot, so read offset then offset+1 for 64 bits
`default_nettype none
`timescale 1ns/1ps

module nts_debug_regs
  import nts_api_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_areset,
  input  api_bus_t              i_bus,
  input  logic                  i_cs,
  input  stat_events_t          i_events,
  output logic [API_DATA_W-1:0] o_read_data
);

  logic [STAT_N-1:0] ev_vec;
  logic [STAT_N-1:0] snap_strobe;
  logic [63:0]       count [STAT_N];
  logic [31:0]       snap_lo [STAT_N];
  logic [31:0]       systick_reg;
  logic              rd_cycle;

  // First struct field lands in the top bit
  assign ev_vec   = i_events;
  assign rd_cycle = i_cs && !i_bus.we;

  // --------------------------------------------------------------------------
  // Event counters
  // --------------------------------------------------------------------------
  for (genvar k = 0; k < STAT_N; k++)
  begin : g_cnt
    nts_stat_counter u_cnt (
      .i_clk     (i_clk),
      .i_areset  (i_areset),
      .i_event   (ev_vec[STAT_N-1-k]),
      .i_snap    (snap_strobe[k]),
      .o_count   (count[k]),
      .o_snap_lo (snap_lo[k])
    );
  end

  // Free-running tick
  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
      systick_reg <= SYSTICK_RESET;
    else
      systick_reg <= systick_reg + 32'd1;
  end

  // --------------------------------------------------------------------------
  // Read decode
  // --------------------------------------------------------------------------
  always_comb
  begin
    o_read_data = '0;
    snap_strobe = '0;
    if (rd_cycle)
    begin
      if (i_bus.address == DBG_NAME)
        o_read_data = DEBUG_NAME;
      if (i_bus.address == DBG_SYSTICK)
        o_read_data = systick_reg;
      for (int k = 0; k < STAT_N; k++)
      begin
        if (i_bus.address == DBG_CNT_OFS[k])
        begin
          o_read_data    = count[k][63:32];
          snap_strobe[k] = 1'b1; // Freeze lower half for the next read
        end
        if (i_bus.address == DBG_CNT_OFS[k] + 8'd1)
          o_read_data = snap_lo[k];
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/nts_engine.sv ====
// Glue layer only; statistics, parser and timestamp writes come in as ports, no back-pressure
`default_nettype none
`timescale 1ns/1ps

module nts_engine
  import nts_api_pkg::*, nts_txbuf_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_areset,
  input  api_req_t              i_api,
  output logic [API_DATA_W-1:0] o_api_read_data,
  input  stat_events_t          i_events,
  input  txbuf_wr_t             i_parser_wr,
  input  ts_hdr_wr_t            i_ts_wr,
  input  logic                  i_sel_ipv4,
  input  logic                  i_sel_ipv6,
  output txbuf_wr_t             o_txbuf_wr
);

  api_bus_t              api_bus;
  logic                  cs_debug;
  logic [API_DATA_W-1:0] debug_rdata;

  nts_api_decode u_api (
    .i_api           (i_api),
    .o_bus           (api_bus),
    .o_cs_debug      (cs_debug),
    .i_debug_rdata   (debug_rdata),
    .o_api_read_data (o_api_read_data)
  );

  nts_debug_regs u_debug (
    .i_clk       (i_clk),
    .i_areset    (i_areset),
    .i_bus       (api_bus),
    .i_cs        (cs_debug),
    .i_events    (i_events),
    .o_read_data (debug_rdata)
  );

  nts_tx_write_mux u_txmux (
    .i_parser_wr (i_parser_wr),
    .i_ts_wr     (i_ts_wr),
    .i_sel_ipv4  (i_sel_ipv4),
    .i_sel_ipv6  (i_sel_ipv6),
    .o_txbuf_wr  (o_txbuf_wr)
  );

endmodule

`default_nettype wire

// ==== src/nts_stat_counter.sv ====
// Counter wraps silently at 2^64; snapshot takes the lower half as it stands before this edge
`default_nettype none
`timescale 1ns/1ps

module nts_stat_counter (
  input  logic        i_clk,
  input  logic        i_areset,
  input  logic        i_event,
  input  logic        i_snap,
  output logic [63:0] o_count,
  output logic [31:0] o_snap_lo
);

  logic [63:0] count_reg;
  logic [31:0] snap_reg;

  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      count_reg <= '0;
      snap_reg  <= '0;
    end
    else
    begin
      if (i_event)
        count_reg <= count_reg + 64'd1;
      if (i_snap)
        snap_reg <= count_reg[31:0]; // Pairs with the upper half read now
    end
  end

  assign o_count   = count_reg;
  assign o_snap_lo = snap_reg;

endmodule

`default_nettype wire

// ==== src/nts_tx_write_mux.sv ====
// Parser address fields are ignored; the parser path always uses the buffer's internal address
`default_nettype none
`timescale 1ns/1ps

module nts_tx_write_mux
  import nts_txbuf_pkg::*;
(
  input  txbuf_wr_t  i_parser_wr,
  input  ts_hdr_wr_t i_ts_wr,
  input  logic       i_sel_ipv4,
  input  logic       i_sel_ipv6,
  output txbuf_wr_t  o_txbuf_wr
);

  logic [TXBUF_ADDR_W-1:0] block_ext;

  assign block_ext = {{(TXBUF_ADDR_W-TS_BLOCK_W){1'b0}}, i_ts_wr.block};

  always_comb
  begin
    // Parser write when neither or both selects are up
    o_txbuf_wr.write_en         = i_parser_wr.write_en;
    o_txbuf_wr.write_data       = i_parser_wr.write_data;
    o_txbuf_wr.address_internal = 1'b1;
    o_txbuf_wr.address_hi       = '0;
    o_txbuf_wr.address_lo       = '0;

    case ({i_sel_ipv6, i_sel_ipv4})
      2'b01:
      begin
        o_txbuf_wr.write_en         = i_ts_wr.wr_en;
        o_txbuf_wr.write_data       = i_ts_wr.data;
        o_txbuf_wr.address_internal = 1'b0;
        o_txbuf_wr.address_hi       = block_ext + IPV4_HDR_HI_BASE;
        o_txbuf_wr.address_lo       = IPV4_HDR_LO;
      end
      2'b10:
      begin
        o_txbuf_wr.write_en         = i_ts_wr.wr_en;
        o_txbuf_wr.write_data       = i_ts_wr.data;
        o_txbuf_wr.address_internal = 1'b0;
        o_txbuf_wr.address_hi       = block_ext + IPV6_HDR_HI_BASE; // Longer IPv6 header
        o_txbuf_wr.address_lo       = IPV6_HDR_LO;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== src/nts_txbuf_pkg.sv ====
// Header placement assumes the timestamp block index never pushes the upper address past 8 bits
`default_nettype none

package nts_txbuf_pkg;

  // --------------------------------------------------------------------------
  // Transmit buffer address space
  // --------------------------------------------------------------------------
  localparam int TXBUF_ADDR_W = 8;  // Upper word address
  localparam int TXBUF_LO_W   = 3;  // Byte lane inside a 64-bit word
  localparam int TS_BLOCK_W   = 3;

  // NTP header position behind the IP and UDP headers
  localparam logic [TXBUF_ADDR_W-1:0] IPV4_HDR_HI_BASE = 8'd5;
  localparam logic [TXBUF_LO_W-1:0]   IPV4_HDR_LO      = 3'd2;
  localparam logic [TXBUF_ADDR_W-1:0] IPV6_HDR_HI_BASE = 8'd7;
  localparam logic [TXBUF_LO_W-1:0]   IPV6_HDR_LO      = 3'd6;

  typedef struct packed {
    logic                    write_en;
    logic [63:0]             write_data;
    logic                    address_internal; // 1 means buffer tracks its own address
    logic [TXBUF_ADDR_W-1:0] address_hi;
    logic [TXBUF_LO_W-1:0]   address_lo;
  } txbuf_wr_t;

  typedef struct packed {
    logic                  wr_en;
    logic [TS_BLOCK_W-1:0] block;
    logic [63:0]           data;
  } ts_hdr_wr_t;

endpackage

`default_nettype wire

// ==== tests/nts_clk_gen.sv ====
// Free-running testbench clock; the period is a whole number of ns and must be even
`default_nettype none
`timescale 1ns/1ps

module nts_clk_gen #(
  parameter int PERIOD_NS = 4
) (
  output logic o_clk
);

  initial o_clk = 1'b0;

  always #(PERIOD_NS / 2) o_clk = ~o_clk; // 50 percent duty

endmodule

`default_nettype wire

// ==== tests/nts_engine_chk.sv ====
// Bound into nts_engine; all properties are disabled while reset is high
`default_nettype none
`timescale 1ns/1ps

module nts_engine_chk
  import nts_api_pkg::*, nts_txbuf_pkg::*;
(
  input logic                  i_clk,
  input logic                  i_areset,
  input api_req_t              i_api,
  input logic [API_DATA_W-1:0] i_read_data,
  input logic                  i_sel_ipv4,
  input logic                  i_sel_ipv6,
  input txbuf_wr_t             i_txbuf_wr
);

  int assert_fails = 0; // Read by the testbench summary

  // API port idles at zero
  a_idle_read_zero: assert property (@(posedge i_clk) disable iff (i_areset)
    !i_api.cs |-> (i_read_data == '0))
  else
  begin
    assert_fails++;
    $error("API read data is not zero while cs is low");
  end

  // Parser path owns the buffer address
  a_parser_internal: assert property (@(posedge i_clk) disable iff (i_areset)
    (!i_sel_ipv4 && !i_sel_ipv6) |-> i_txbuf_wr.address_internal)
  else
  begin
    assert_fails++;
    $error("address_internal is low with no header select");
  end

  a_ipv4_lo: assert property (@(posedge i_clk) disable iff (i_areset)
    (i_sel_ipv4 && !i_sel_ipv6) |-> (i_txbuf_wr.address_lo == IPV4_HDR_LO))
  else
  begin
    assert_fails++;
    $error("IPv4 header write has the wrong lower address");
  end

endmodule

bind nts_engine nts_engine_chk u_chk (
  .i_clk       (i_clk),
  .i_areset    (i_areset),
  .i_api       (i_api),
  .i_read_data (o_api_read_data),
  .i_sel_ipv4  (i_sel_ipv4),
  .i_sel_ipv6  (i_sel_ipv6),
  .i_txbuf_wr  (o_txbuf_wr)
);

`default_nettype wire

// ==== tests/nts_engine_tb.sv ====
// Directed tests for the glue layer; expects nts_engine_chk bound as u_chk inside the DUT
`default_nettype none
`timescale 1ns/1ps

module nts_engine_tb
  import nts_api_pkg::*, nts_txbuf_pkg::*;
();

  localparam int CLK_PERIOD_NS = 4;
  localparam int RESET_CYCLES  = 8;
  localparam int MAX_PULSES    = 20;
  localparam int MAX_GAP       = 16;
  localparam int TX_ROUNDS     = 8;
  // Rough cycle budget of all tests together
  localparam int TEST_CYCLES   = RESET_CYCLES + 20 + STAT_N * (4 * MAX_PULSES + 12)
                                 + MAX_GAP + 8 + 4 * TX_ROUNDS;
  localparam int WATCHDOG_NS   = 20 * TEST_CYCLES * CLK_PERIOD_NS;

  logic                  clk;
  logic                  areset;
  api_req_t              api_req;
  logic [API_DATA_W-1:0] api_rdata;
  stat_events_t          events;
  txbuf_wr_t             parser_wr;
  ts_hdr_wr_t            ts_wr;
  logic                  sel_ipv4;
  logic                  sel_ipv6;
  txbuf_wr_t             txbuf_wr;

  int          word_errors;
  int          txwr_errors;
  int          edges_since_rst;
  int          sampled_edges;
  logic [63:0] exp_count [STAT_N];

  nts_clk_gen #(.PERIOD_NS(CLK_PERIOD_NS)) u_clk (.o_clk(clk));

  nts_engine dut (
    .i_clk           (clk),
    .i_areset        (areset),
    .i_api           (api_req),
    .o_api_read_data (api_rdata),
    .i_events        (events),
    .i_parser_wr     (parser_wr),
    .i_ts_wr         (ts_wr),
    .i_sel_ipv4      (sel_ipv4),
    .i_sel_ipv6      (sel_ipv6),
    .o_txbuf_wr      (txbuf_wr)
  );

  // Edges seen since reset release, the reference for the tick
  always @(posedge clk)
  begin
    if (areset)
      edges_since_rst <= 0;
    else
      edges_since_rst <= edges_since_rst + 1;
  end

  // --------------------------------------------------------------------------
  // Compare tasks and helpers
  // --------------------------------------------------------------------------
  task automatic check_word(input string name, input logic [API_DATA_W-1:0] exp,
                            input logic [API_DATA_W-1:0] act);
    if (act !== exp)
    begin
      $display("MISMATCH t=%0t %s expected %h actual %h", $time, name, exp, act);
      word_errors++;
    end
  endtask

  task automatic check_txwr(input txbuf_wr_t exp, input txbuf_wr_t act);
    if (act !== exp)
    begin
      $display("MISMATCH t=%0t o_txbuf_wr expected %h actual %h", $time, exp, act);
      txwr_errors++;
    end
  endtask

  // One request cycle, sampled mid-cycle, then an idle cycle
  task automatic api_access(input logic we, input logic [API_ADDR_W-1:0] addr,
                            output logic [API_DATA_W-1:0] data);
    @(posedge clk);
    api_req <= '{cs: 1'b1, we: we, address: addr, write_data: $urandom};
    @(negedge clk);
    data          = api_rdata;
    sampled_edges = edges_since_rst;
    @(posedge clk);
    api_req <= '0; // Snapshot is taken at this edge
  endtask

  function automatic stat_events_t event_mask(input int k);
    stat_events_t m;
    m = '0;
    case (k)
      0: m.processed  = 1'b1;
      1: m.bad_cookie = 1'b1;
      2: m.bad_auth   = 1'b1;
      3: m.bad_keyid  = 1'b1;
      4: m.err_crypto = 1'b1;
      default: m.err_txbuf = 1'b1;
    endcase
    return m;
  endfunction

  function automatic logic [API_REG_W-1:0] cnt_offset(input int k);
    case (k)
      0: return DBG_PROCESSED;
      1: return DBG_BAD_COOKIE;
      2: return DBG_BAD_AUTH;
      3: return DBG_BAD_KEYID;
      4: return DBG_ERR_CRYPTO;
      default: return DBG_ERR_TXBUF;
    endcase
  endfunction

  task automatic pulse_event(input int k, input int n);
    repeat (n)
    begin
      @(posedge clk);
      events <= event_mask(k);
      @(posedge clk);
      events <= '0;
    end
    exp_count[k] = exp_count[k] + 64'(n);
  endtask

  function automatic txbuf_wr_t expected_tx(input txbuf_wr_t p, input ts_hdr_wr_t t,
                                            input logic v4, input logic v6);
    txbuf_wr_t e;
    e = '{write_en: p.write_en, write_data: p.write_data, address_internal: 1'b1,
          address_hi: 8'd0, address_lo: 3'd0};
    if (v4 != v6)
    begin
      e.write_en         = t.wr_en;
      e.write_data       = t.data;
      e.address_internal = 1'b0;
      e.address_hi       = {5'd0, t.block} + (v4 ? IPV4_HDR_HI_BASE : IPV6_HDR_HI_BASE);
      e.address_lo       = v4 ? IPV4_HDR_LO : IPV6_HDR_LO;
    end
    return e;
  endfunction

  // --------------------------------------------------------------------------
  // Directed tests
  // --------------------------------------------------------------------------
  task automatic test_identity();
    logic [API_DATA_W-1:0] d;
    api_access(1'b0, {BLK_ENGINE, REG_NAME0}, d);
    check_word("o_api_read_data name0", CORE_NAME0, d);
    api_access(1'b0, {BLK_ENGINE, REG_NAME1}, d);
    check_word("o_api_read_data name1", CORE_NAME1, d);
    api_access(1'b0, {BLK_ENGINE, REG_VERSION}, d);
    check_word("o_api_read_data version", CORE_VERSION, d);
    api_access(1'b0, {BLK_ENGINE, REG_CTRL}, d);
    check_word("o_api_read_data ctrl", CTRL_VALUE, d);
    api_access(1'b0, {BLK_ENGINE, 8'h03}, d);
    check_word("o_api_read_data unmapped", '0, d);
    api_access(1'b0, {BLK_DEBUG, DBG_NAME}, d);
    check_word("o_api_read_data debug name", DEBUG_NAME, d);
    api_access(1'b0, {4'd2, REG_NAME0}, d);
    check_word("o_api_read_data block 2", '0, d);
    api_access(1'b1, {BLK_ENGINE, REG_NAME0}, d); // Write cycle
    check_word("o_api_read_data on write", '0, d);
  endtask

  task automatic test_counters();
    logic [API_DATA_W-1:0] d;
    for (int k = 0; k < STAT_N; k++)
    begin
      pulse_event(k, 1 + $urandom_range(MAX_PULSES - 1));
      api_access(1'b0, {BLK_DEBUG, cnt_offset(k)}, d);
      check_word("o_api_read_data counter hi", exp_count[k][63:32], d);
      api_access(1'b0, {BLK_DEBUG, cnt_offset(k) + 8'd1}, d);
      check_word("o_api_read_data counter lo", exp_count[k][31:0], d);
    end
  endtask

  task automatic test_snapshot_hold();
    logic [API_DATA_W-1:0] d;
    logic [31:0]           held;
    for (int k = 0; k < STAT_N; k++)
    begin
      api_access(1'b0, {BLK_DEBUG, cnt_offset(k)}, d);
      held = exp_count[k][31:0];
      pulse_event(k, 1 + $urandom_range(MAX_PULSES - 1));
      api_access(1'b0, {BLK_DEBUG, cnt_offset(k) + 8'd1}, d);
      check_word("o_api_read_data held snapshot", held, d);
      api_access(1'b0, {BLK_DEBUG, cnt_offset(k)}, d);
      check_word("o_api_read_data counter hi", exp_count[k][63:32], d);
      api_access(1'b0, {BLK_DEBUG, cnt_offset(k) + 8'd1}, d);
      check_word("o_api_read_data new snapshot", exp_count[k][31:0], d);
    end
  endtask

  task automatic test_systick();
    logic [API_DATA_W-1:0] t1;
    logic [API_DATA_W-1:0] t2;
    int                    gap;
    int                    first_edges;
    gap = 1 + $urandom_range(MAX_GAP - 1);
    api_access(1'b0, {BLK_DEBUG, DBG_SYSTICK}, t1);
    first_edges = sampled_edges;
    check_word("o_api_read_data systick", 32'd1 + 32'(first_edges), t1);
    repeat (gap) @(posedge clk);
    api_access(1'b0, {BLK_DEBUG, DBG_SYSTICK}, t2);
    // Idle edge of the first access plus the request edge of the second
    check_word("o_api_read_data systick delta", 32'd1 + 32'(first_edges + gap + 2), t2);
  endtask

  task automatic test_tx_router();
    txbuf_wr_t  p;
    ts_hdr_wr_t t;
    for (int c = 0; c < 4; c++)
    begin
      for (int r = 0; r < TX_ROUNDS; r++)
      begin
        p = '{write_en: 1'($urandom), write_data: {$urandom, $urandom},
              address_internal: 1'($urandom), address_hi: 8'($urandom),
              address_lo: 3'($urandom)};
        t = '{wr_en: 1'($urandom), block: 3'($urandom), data: {$urandom, $urandom}};
        @(posedge clk);
        parser_wr <= p;
        ts_wr     <= t;
        sel_ipv4  <= c[0];
        sel_ipv6  <= c[1];
        @(negedge clk);
        check_txwr(expected_tx(p, t, c[0], c[1]), txbuf_wr);
      end
    end
  endtask

  // --------------------------------------------------------------------------
  // Sequence, summary and watchdog
  // --------------------------------------------------------------------------
  initial
  begin
    int seed_value;
    seed_value  = $urandom(32'h29a6);
    areset      = 1'b1;
    api_req     = '0;
    events      = '0;
    parser_wr   = '0;
    ts_wr       = '0;
    sel_ipv4    = 1'b0;
    sel_ipv6    = 1'b0;
    word_errors = 0;
    txwr_errors = 0;
    for (int k = 0; k < STAT_N; k++)
      exp_count[k] = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    areset <= 1'b0;

    test_systick();
    test_identity();
    test_counters();
    test_snapshot_hold();
    test_tx_router();

    @(posedge clk);
    $display("Summary: %0d word mismatches, %0d txbuf mismatches, %0d assertion failures",
             word_errors, txwr_errors, dut.u_chk.assert_fails);
    if (word_errors + txwr_errors + dut.u_chk.assert_fails == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns before the tests completed", WATCHDOG_NS);
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire
